// ==== hdl/sbus_arbiter.sv ====
`timescale 1ns/10ps

module sbus_arbiter
(
    input  logic       clk,
    input  logic       rstn,
    input  logic [1:0] request,
    output logic [1:0] grant
);
    logic last_served;   // 1 when master 1 had the bus last
    logic bus_free;

    // The holder keeps the bus until its request drops
    assign bus_free = !(|(grant & request));

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            grant       <= 2'b00;
            last_served <= 1'b1;                            // Master 0 goes first
        end
        else if (bus_free)
        begin
            if (request[0] && (!request[1] || last_served))
            begin
                grant       <= 2'b01;
                last_served <= 1'b0;
            end
            else if (request[1])
            begin
                grant       <= 2'b10;
                last_served <= 1'b1;
            end
            else
            begin
                grant <= 2'b00;
            end
        end
    end

endmodule

// ==== hdl/sbus_defs.svh ====
`ifndef SBUS_DEFS_SVH
`define SBUS_DEFS_SVH

// Address carried by an address frame
`define SBUS_ADDR_W 15

// Memory word and data frame payload
`define SBUS_DATA_W 8

// Ack wait expires when the counter is all ones
`define SBUS_TIMEOUT_W 6

// Words held by the memory slave
`define SBUS_MEM_DEPTH 256

`endif

// ==== hdl/sbus_master.sv ====
`timescale 1ns/10ps
`include "sbus_defs.svh"

module sbus_master
    import sbus_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  master_req_t req,
    input  logic        grant,
    input  logic        line_in,
    output master_rsp_t rsp,
    output logic        request,
    output bus_ctrl_t   ctrl,
    output logic        line_out
);
    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_REQ      = 3'd1;
    localparam logic [2:0] ST_GRANTED  = 3'd2;
    localparam logic [2:0] ST_ADDR     = 3'd3;
    localparam logic [2:0] ST_ADDR_ACK = 3'd4;
    localparam logic [2:0] ST_WR_SEND  = 3'd5;
    localparam logic [2:0] ST_DATA_ACK = 3'd6;
    localparam logic [2:0] ST_RD_RECV  = 3'd7;

    logic [2:0]                 state;
    logic [`SBUS_TIMEOUT_W-1:0] tout;
    logic                       busy_r;
    logic                       dvalid_r;
    logic                       err_r;
    logic                       rw_r;
    logic                       send_r;
    logic [`SBUS_ADDR_W-1:0]    addr_r;
    logic [`SBUS_DATA_W-1:0]    wdata_r;
    logic [`SBUS_DATA_W-1:0]    rdata_r;
    logic                       waiting;
    logic                       expired;
    logic                       tx_done;
    logic                       rx_done;
    frame_kind_t                kind;
    shift_word_u                tx_word;
    shift_word_u                rx_word;

    assign waiting = (state == ST_ADDR_ACK) || (state == ST_DATA_ACK) || (state == ST_RD_RECV);
    assign expired = waiting && (tout == '1);

    assign ctrl.utilizing = (state != ST_IDLE) && (state != ST_REQ);
    assign ctrl.rw        = ctrl.utilizing && rw_r;

    assign rsp = '{busy: busy_r, dvalid: dvalid_r, err: err_r, rdata: rdata_r};

    always_comb
    begin
        case (state)
            ST_ADDR_ACK:            kind = FRAME_ADDR_ACK;
            ST_WR_SEND, ST_RD_RECV: kind = FRAME_DATA;
            ST_DATA_ACK:            kind = FRAME_DATA_ACK;
            default:                kind = FRAME_ADDR;
        endcase
    end

    always_comb
    begin
        tx_word = '0;
        if (state == ST_WR_SEND)
            tx_word.dview.data = wdata_r;
        else
            tx_word.addr = addr_r;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state    <= ST_IDLE;
            tout     <= '0;
            request  <= 1'b0;
            busy_r   <= 1'b0;
            dvalid_r <= 1'b0;
            err_r    <= 1'b0;
            rw_r     <= 1'b0;
            send_r   <= 1'b0;
        end
        else
        begin
            dvalid_r <= 1'b0;
            err_r    <= 1'b0;
            send_r   <= 1'b0;
            tout     <= waiting ? tout + 1'b1 : '0;
            case (state)
                ST_IDLE:
                begin
                    if (req.hold)
                    begin
                        request <= 1'b1;
                        busy_r  <= 1'b1;
                        state   <= ST_REQ;
                    end
                end
                ST_REQ:
                begin
                    if (!req.hold)
                    begin
                        request <= 1'b0;
                        busy_r  <= 1'b0;
                        state   <= ST_IDLE;
                    end
                    else if (grant)
                    begin
                        busy_r <= 1'b0;                   // Ready for commands
                        state  <= ST_GRANTED;
                    end
                end
                ST_GRANTED:
                begin
                    if (!req.hold)
                    begin
                        request <= 1'b0;
                        state   <= ST_IDLE;
                    end
                    else if (req.execute)
                    begin
                        busy_r <= 1'b1;
                        rw_r   <= req.rw;
                        send_r <= 1'b1;
                        state  <= ST_ADDR;
                    end
                end
                ST_ADDR:
                begin
                    if (tx_done)
                        state <= ST_ADDR_ACK;
                end
                ST_ADDR_ACK:
                begin
                    if (rx_done && rw_r)
                    begin
                        send_r <= 1'b1;
                        state  <= ST_WR_SEND;
                    end
                    else if (rx_done)
                    begin
                        tout  <= '0;                       // Fresh wait for read data
                        state <= ST_RD_RECV;
                    end
                end
                ST_WR_SEND:
                begin
                    if (tx_done)
                        state <= ST_DATA_ACK;
                end
                ST_DATA_ACK, ST_RD_RECV:
                begin
                    if (rx_done)
                    begin
                        dvalid_r <= 1'b1;
                        busy_r   <= 1'b0;
                        state    <= ST_GRANTED;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (expired && !rx_done)                       // Nobody answered
            begin
                err_r  <= 1'b1;
                busy_r <= 1'b0;
                state  <= ST_GRANTED;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ST_GRANTED && req.hold && req.execute)
        begin
            addr_r  <= req.addr;
            wdata_r <= req.wdata;
        end
        if (state == ST_RD_RECV && rx_done)
            rdata_r <= rx_word.dview.data;
    end

    sbus_shifter u_shifter (
        .clk      (clk),
        .rstn     (rstn),
        .send     (send_r),
        .rx_en    (waiting),
        .kind     (kind),
        .tx_word  (tx_word),
        .line_in  (line_in),
        .line_out (line_out),
        .tx_done  (tx_done),
        .rx_done  (rx_done),
        .rx_word  (rx_word)
    );

endmodule

// ==== hdl/sbus_pkg.sv ====
`include "sbus_defs.svh"

package sbus_pkg;

    // Bit 0 of the kind is also the second prefix bit on the line
    typedef enum logic [1:0]
    {
        FRAME_ADDR     = 2'b00,  // Prefix 00 then the address
        FRAME_DATA     = 2'b01,  // Prefix 01 then one data byte
        FRAME_ADDR_ACK = 2'b10,  // Prefix 00 alone
        FRAME_DATA_ACK = 2'b11   // Prefix 01 alone
    } frame_kind_t;

    typedef struct packed
    {
        logic [`SBUS_DATA_W-1:0]              data;
        logic [`SBUS_ADDR_W-`SBUS_DATA_W-1:0] pad;   // Unused low bits
    } data_view_t;

    typedef union packed
    {
        logic [`SBUS_ADDR_W-1:0] addr;
        data_view_t              dview;
    } shift_word_u;

    typedef struct packed
    {
        logic                    hold;
        logic                    execute;
        logic                    rw;      // 1 means write
        logic [`SBUS_ADDR_W-1:0] addr;
        logic [`SBUS_DATA_W-1:0] wdata;
    } master_req_t;

    typedef struct packed
    {
        logic                    busy;
        logic                    dvalid;
        logic                    err;
        logic [`SBUS_DATA_W-1:0] rdata;
    } master_rsp_t;

    typedef struct packed
    {
        logic utilizing;
        logic rw;
    } bus_ctrl_t;

endpackage

// ==== hdl/sbus_shifter.sv ====
`timescale 1ns/10ps
`include "sbus_defs.svh"

module sbus_shifter
    import sbus_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        send,
    input  logic        rx_en,
    input  frame_kind_t kind,
    input  shift_word_u tx_word,
    input  logic        line_in,
    output logic        line_out,
    output logic        tx_done,
    output logic        rx_done,
    output shift_word_u rx_word
);
    localparam logic [1:0] SH_IDLE = 2'd0;
    localparam logic [1:0] SH_TX   = 2'd1;
    localparam logic [1:0] SH_RX   = 2'd2;

    logic [1:0]  mode;
    logic [4:0]  cnt;       // Bit position inside the frame
    logic [4:0]  last;      // Position of the final bit
    logic [3:0]  pay_idx;
    logic        pfx_bit;
    logic        tx_bit;
    shift_word_u tx_sh;

    always_comb
    begin
        case (kind)
            FRAME_ADDR: last = 5'(`SBUS_ADDR_W + 1);
            FRAME_DATA: last = 5'(`SBUS_DATA_W + 1);
            default:    last = 5'd1;                   // Acks are the prefix alone
        endcase
    end

    assign pfx_bit  = kind[0];
    assign pay_idx  = 4'(`SBUS_ADDR_W + 1 - cnt);      // MSB first after the prefix
    assign tx_bit   = (cnt == 5'd0) ? 1'b0 : (cnt == 5'd1) ? pfx_bit : tx_sh.addr[pay_idx];
    assign line_out = (mode == SH_TX) ? tx_bit : 1'b1;
    assign tx_done  = (mode == SH_TX) && (cnt == last);

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            mode    <= SH_IDLE;
            cnt     <= 5'd0;
            rx_done <= 1'b0;
        end
        else
        begin
            rx_done <= 1'b0;
            case (mode)
                SH_IDLE:
                begin
                    if (send)
                    begin
                        mode <= SH_TX;
                        cnt  <= 5'd0;
                    end
                    else if (rx_en && !line_in)             // Every prefix starts with 0
                    begin
                        mode <= SH_RX;
                        cnt  <= 5'd1;
                    end
                end
                SH_TX:
                begin
                    cnt <= cnt + 5'd1;
                    if (tx_done)
                        mode <= SH_IDLE;
                end
                SH_RX:
                begin
                    cnt <= cnt + 5'd1;
                    if (!rx_en || (cnt == 5'd1 && line_in != pfx_bit))
                        mode <= SH_IDLE;                   // Not the frame we wait for
                    else if (cnt == last)
                    begin
                        mode    <= SH_IDLE;
                        rx_done <= 1'b1;
                    end
                end
                default: mode <= SH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (send && mode == SH_IDLE)
            tx_sh <= tx_word;
        if (mode == SH_RX && cnt >= 5'd2)
            rx_word.addr[pay_idx] <= line_in;
    end

endmodule

// ==== hdl/sbus_slave.sv ====
`timescale 1ns/10ps
`include "sbus_defs.svh"

module sbus_slave
    import sbus_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  bus_ctrl_t ctrl,
    input  logic      line_in,
    output logic      line_out
);
    localparam int MEM_AW = $clog2(`SBUS_MEM_DEPTH);
    localparam logic [`SBUS_ADDR_W-1:0] DEPTH = `SBUS_MEM_DEPTH;

    localparam logic [2:0] SL_LISTEN  = 3'd0;
    localparam logic [2:0] SL_ACK     = 3'd1;
    localparam logic [2:0] SL_WR_RECV = 3'd2;
    localparam logic [2:0] SL_DACK    = 3'd3;
    localparam logic [2:0] SL_RD      = 3'd4;

    logic [2:0]              state;
    logic                    rw_r;
    logic                    rd_go;
    logic [MEM_AW-1:0]       addr_r;
    logic [`SBUS_DATA_W-1:0] mem [`SBUS_MEM_DEPTH];
    logic                    addr_hit;
    logic                    data_hit;
    logic                    send;
    logic                    rx_en;
    logic                    tx_done;
    logic                    rx_done;
    frame_kind_t             kind;
    shift_word_u             tx_word;
    shift_word_u             rx_word;

    assign addr_hit = (state == SL_LISTEN) && rx_done && (rx_word.addr < DEPTH);
    assign data_hit = (state == SL_WR_RECV) && rx_done;
    assign send     = addr_hit || data_hit || rd_go;   // Acks leave one idle cycle
    assign rx_en    = ((state == SL_LISTEN) && ctrl.utilizing) || (state == SL_WR_RECV);

    always_comb
    begin
        case (state)
            SL_ACK:            kind = FRAME_ADDR_ACK;
            SL_WR_RECV, SL_RD: kind = FRAME_DATA;
            SL_DACK:           kind = FRAME_DATA_ACK;
            default:           kind = FRAME_ADDR;
        endcase
    end

    always_comb
    begin
        tx_word            = '0;
        tx_word.dview.data = mem[addr_r];
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= SL_LISTEN;
            rw_r  <= 1'b0;
            rd_go <= 1'b0;
        end
        else
        begin
            rd_go <= 1'b0;
            case (state)
                SL_LISTEN:
                begin
                    if (addr_hit)                           // Out of range stays silent
                    begin
                        rw_r  <= ctrl.rw;
                        state <= SL_ACK;
                    end
                end
                SL_ACK:
                begin
                    if (tx_done)
                    begin
                        rd_go <= !rw_r;
                        state <= rw_r ? SL_WR_RECV : SL_RD;
                    end
                end
                SL_WR_RECV:
                begin
                    if (data_hit)
                        state <= SL_DACK;
                    else if (!ctrl.utilizing)
                        state <= SL_LISTEN;
                end
                SL_DACK, SL_RD:
                begin
                    if (tx_done)
                        state <= SL_LISTEN;
                end
                default: state <= SL_LISTEN;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == SL_LISTEN && rx_done)
            addr_r <= rx_word.addr[MEM_AW-1:0];
        if (data_hit)
            mem[addr_r] <= rx_word.dview.data;
    end

    sbus_shifter u_shifter (
        .clk      (clk),
        .rstn     (rstn),
        .send     (send),
        .rx_en    (rx_en),
        .kind     (kind),
        .tx_word  (tx_word),
        .line_in  (line_in),
        .line_out (line_out),
        .tx_done  (tx_done),
        .rx_done  (rx_done),
        .rx_word  (rx_word)
    );

endmodule

// ==== hdl/sbus_top.sv ====
`timescale 1ns/10ps

module sbus_top
    import sbus_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  master_req_t m0_req,
    input  master_req_t m1_req,
    output master_rsp_t m0_rsp,
    output master_rsp_t m1_rsp
);
    logic [1:0] request;
    logic [1:0] grant;
    bus_ctrl_t  m0_ctrl;
    bus_ctrl_t  m1_ctrl;
    bus_ctrl_t  s_ctrl;
    logic       m0_line;
    logic       m1_line;
    logic       s_line;
    logic       line;

    assign line = m0_line & m1_line & s_line;   // Silent agents drive 1

    // Only the granted master steers the slave
    always_comb
    begin
        if (grant[0])
            s_ctrl = m0_ctrl;
        else if (grant[1])
            s_ctrl = m1_ctrl;
        else
            s_ctrl = '0;
    end

    sbus_master u_master0 (
        .clk      (clk),
        .rstn     (rstn),
        .req      (m0_req),
        .grant    (grant[0]),
        .line_in  (line),
        .rsp      (m0_rsp),
        .request  (request[0]),
        .ctrl     (m0_ctrl),
        .line_out (m0_line)
    );

    sbus_master u_master1 (
        .clk      (clk),
        .rstn     (rstn),
        .req      (m1_req),
        .grant    (grant[1]),
        .line_in  (line),
        .rsp      (m1_rsp),
        .request  (request[1]),
        .ctrl     (m1_ctrl),
        .line_out (m1_line)
    );

    sbus_arbiter u_arbiter (
        .clk     (clk),
        .rstn    (rstn),
        .request (request),
        .grant   (grant)
    );

    sbus_slave u_slave (
        .clk      (clk),
        .rstn     (rstn),
        .ctrl     (s_ctrl),
        .line_in  (line),
        .line_out (s_line)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the sbus testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module sbus_tb -f sbus.f -o sbus_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/sbus_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Test failures found" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "PASS"
exit 0

// ==== sbus.f ====
+incdir+hdl
hdl/sbus_pkg.sv
hdl/sbus_shifter.sv
hdl/sbus_master.sv
hdl/sbus_arbiter.sv
hdl/sbus_slave.sv
hdl/sbus_top.sv
verification/sbus_chk.sv
verification/sbus_tb.sv

// ==== verification/sbus_chk.sv ====
`timescale 1ns/10ps

module sbus_chk
    import sbus_pkg::*;
(
    input logic        clk,
    input logic        rstn,
    input logic [1:0]  grant,
    input master_rsp_t m0_rsp,
    input master_rsp_t m1_rsp
);

    grant_single: assert property (@(posedge clk) disable iff (!rstn) grant != 2'b11)
        else $error("grant given to both masters at once");

    // A command ends either well or badly, never both
    end_exclusive: assert property (@(posedge clk) disable iff (!rstn)
        !(m0_rsp.dvalid && m0_rsp.err) && !(m1_rsp.dvalid && m1_rsp.err))
        else $error("dvalid and err high together");

    dvalid_pulse: assert property (@(posedge clk) disable iff (!rstn)
        !(m0_rsp.dvalid && $past(m0_rsp.dvalid)) && !(m1_rsp.dvalid && $past(m1_rsp.dvalid)))
        else $error("dvalid high on two consecutive cycles");

endmodule

bind sbus_top sbus_chk u_chk (
    .clk    (clk),
    .rstn   (rstn),
    .grant  (grant),
    .m0_rsp (m0_rsp),
    .m1_rsp (m1_rsp)
);

// ==== verification/sbus_tb.sv ====
`timescale 1ns/10ps
`include "sbus_defs.svh"

module sbus_tb
    import sbus_pkg::*;
();
    localparam int N_WR     = 6;
    localparam int N_ROWS   = 3 * N_WR + 3;
    localparam int WAIT_MAX = 500;

    typedef struct packed
    {
        logic                    idx;     // Master index
        logic                    rw;      // 1 means write
        logic [`SBUS_ADDR_W-1:0] addr;
        logic [`SBUS_DATA_W-1:0] wdata;
    } row_t;

    logic        clk;
    logic        rstn;
    master_req_t m0_req;
    master_req_t m1_req;
    master_rsp_t m0_rsp;
    master_rsp_t m1_rsp;

    row_t                    rows [N_ROWS];
    logic [`SBUS_DATA_W-1:0] ref_mem [`SBUS_MEM_DEPTH];   // Unknown until written
    logic [`SBUS_DATA_W-1:0] last_rd [2];
    logic                    rd_seen [2];
    integer                  seed;

    sbus_top u_dut (
        .clk    (clk),
        .rstn   (rstn),
        .m0_req (m0_req),
        .m1_req (m1_req),
        .m0_rsp (m0_rsp),
        .m1_rsp (m1_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    function automatic master_rsp_t rsp_of(input logic idx);
        return idx ? m1_rsp : m0_rsp;
    endfunction

    function automatic string rsp_name(input logic idx);
        return idx ? "m1_rsp" : "m0_rsp";
    endfunction

    task automatic check_busy(input string name, input master_rsp_t got, input logic exp);
        if (got.busy !== exp)
        begin
            $display("error: %s.busy got %h expected %h", name, got.busy, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_rsp(input string name, input master_rsp_t got, input logic exp_dvalid,
                             input logic exp_err, input logic chk_rdata,
                             input logic [`SBUS_DATA_W-1:0] exp_rdata);
        if (got.dvalid !== exp_dvalid)
        begin
            $display("error: %s.dvalid got %h expected %h", name, got.dvalid, exp_dvalid);
            stop_on_failure();
        end
        if (got.err !== exp_err)
        begin
            $display("error: %s.err got %h expected %h", name, got.err, exp_err);
            stop_on_failure();
        end
        if (chk_rdata && got.rdata !== exp_rdata)
        begin
            $display("error: %s.rdata got %h expected %h", name, got.rdata, exp_rdata);
            stop_on_failure();
        end
    endtask

    task automatic drive_hold(input logic idx, input logic value);
        @(posedge clk);
        if (idx)
            m1_req.hold <= value;
        else
            m0_req.hold <= value;
    endtask

    task automatic wait_busy(input logic idx, input logic level);
        int          n;
        master_rsp_t r;
        n = 0;
        @(negedge clk);
        r = rsp_of(idx);
        while (r.busy !== level)
        begin
            n = n + 1;
            if (n > WAIT_MAX)
            begin
                $display("timeout: busy of master %0d never went to %0d", idx, level);
                stop_on_failure();
            end
            @(negedge clk);
            r = rsp_of(idx);
        end
    endtask

    task automatic acquire(input logic idx);
        drive_hold(idx, 1'b1);
        wait_busy(idx, 1'b1);                       // Request pending
        wait_busy(idx, 1'b0);                       // Granted and ready
    endtask

    task automatic run_row(input row_t row);
        int          n;
        master_rsp_t r;
        master_req_t cmd;
        logic        exp_err;
        exp_err = (row.addr >= `SBUS_MEM_DEPTH);
        cmd     = '{hold: 1'b1, execute: 1'b1, rw: row.rw, addr: row.addr, wdata: row.wdata};
        @(posedge clk);
        if (row.idx)
            m1_req <= cmd;
        else
            m0_req <= cmd;
        cmd.execute = 1'b0;
        @(posedge clk);
        if (row.idx)
            m1_req <= cmd;
        else
            m0_req <= cmd;
        @(negedge clk);
        r = rsp_of(row.idx);
        check_busy(rsp_name(row.idx), r, 1'b1);
        n = 0;
        while (!(r.dvalid || r.err))
        begin
            n = n + 1;
            if (n > WAIT_MAX)
            begin
                $display("timeout: master %0d command got neither dvalid nor err", row.idx);
                stop_on_failure();
            end
            @(negedge clk);
            r = rsp_of(row.idx);
        end
        if (!exp_err && row.rw)
            ref_mem[row.addr] = row.wdata;
        if (!exp_err && !row.rw)
        begin
            last_rd[row.idx] = ref_mem[row.addr];
            rd_seen[row.idx] = 1'b1;
        end
        // rdata keeps the last read on writes and errors
        check_rsp(rsp_name(row.idx), r, !exp_err, exp_err, rd_seen[row.idx], last_rd[row.idx]);
        check_busy(rsp_name(row.idx), r, 1'b0);
    endtask

    task automatic apply_rows(input int first, input int last_row);
        for (int i = first; i <= last_row; i++)
            run_row(rows[i]);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        for (int i = 0; i < N_WR; i++)
        begin
            rnd                  = $random(seed);
            rows[i]              = '{1'b0, 1'b1, {7'd0, rnd[7:0]}, rnd[15:8]};
            rows[N_WR + i]       = '{1'b0, 1'b0, {7'd0, rnd[7:0]}, 8'h00};
            rows[3*N_WR - 1 - i] = '{1'b1, 1'b0, {7'd0, rnd[7:0]}, 8'h00};   // Peer reads back
        end
        rnd              = $random(seed);
        rows[3*N_WR]     = '{1'b1, 1'b1, 15'(`SBUS_MEM_DEPTH) + {7'd0, rnd[7:0]}, rnd[15:8]};
        rows[3*N_WR + 1] = '{1'b1, 1'b0, 15'h7fff, 8'h00};
        rows[3*N_WR + 2] = rows[2*N_WR];                                     // Memory still intact
    endtask

    initial
    begin
        seed       = 32'hf678ae0c;
        rd_seen[0] = 1'b0;
        rd_seen[1] = 1'b0;
        rstn   <= 1'b0;
        m0_req <= '0;
        m1_req <= '0;
        build_table();
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_busy("m0_rsp", m0_rsp, 1'b0);
        check_busy("m1_rsp", m1_rsp, 1'b0);
        check_rsp("m0_rsp", m0_rsp, 1'b0, 1'b0, 1'b0, 8'h00);
        check_rsp("m1_rsp", m1_rsp, 1'b0, 1'b0, 1'b0, 8'h00);

        // Master 0 writes then reads back
        acquire(1'b0);
        apply_rows(0, 2*N_WR - 1);
        drive_hold(1'b0, 1'b0);

        // Master 1 owns the bus so master 0 keeps waiting
        acquire(1'b1);
        drive_hold(1'b0, 1'b1);
        wait_busy(1'b0, 1'b1);
        repeat (20)
        begin
            @(negedge clk);
            check_busy("m0_rsp", m0_rsp, 1'b1);
        end
        drive_hold(1'b1, 1'b0);
        wait_busy(1'b0, 1'b0);
        drive_hold(1'b0, 1'b0);

        // Shared memory seen from master 1, then out of range commands
        acquire(1'b1);
        apply_rows(2*N_WR, N_ROWS - 1);
        drive_hold(1'b1, 1'b0);
        repeat (4) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule
